// File: hw/isaPkg.sv
package isaPkg;

   // Data and address word
   typedef logic [31:0] word_t;
   // Register number
   typedef logic [4:0] regAddr_t;
   // Raw instruction fields
   typedef logic [15:0] imm_t;
   typedef logic [25:0] target_t;

   // Field positions inside an instruction word
   parameter int opcodeLsb = 26;
   parameter int rsLsb = 21;
   parameter int rtLsb = 16;
   parameter int rdLsb = 11;
   parameter int shamtLsb = 6;

   // Primary opcodes, SPECIAL selects R-type
   typedef enum logic [5:0] {
      opSpecial = 6'h00,
      opJ       = 6'h02,
      opJal     = 6'h03,
      opBeq     = 6'h04,
      opBne     = 6'h05,
      opAddiu   = 6'h09,
      opOri     = 6'h0d,
      opLui     = 6'h0f,
      opLw      = 6'h23,
      opSw      = 6'h2b
   } opcode_t;

   // R-type function codes
   typedef enum logic [5:0] {
      fnSll  = 6'h00,
      fnSrl  = 6'h02,
      fnJr   = 6'h08,
      fnAddu = 6'h21,
      fnSubu = 6'h23,
      fnAnd  = 6'h24,
      fnOr   = 6'h25,
      fnXor  = 6'h26,
      fnSlt  = 6'h2a
   } funct_t;

   // JAL link target
   parameter regAddr_t linkReg = 5'd31;

endpackage

// File: hw/pipePkg.sv
package pipePkg;

   // ALU function, picked in decode
   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluXor,
      aluSlt,
      aluSll,
      aluSrl,
      aluLui
   } aluOp_t;

   // Where the next fetch address comes from
   typedef enum logic [1:0] {
      pcSeq,
      pcBranch,
      pcJump,
      pcReg
   } pcSel_t;

   // Sequential PC increment
   parameter int pcStep = 4;
   // Link value is the jump's own PC plus this (skips the delay slot)
   parameter int linkOffset = 8;

endpackage

// File: hw/stageIf.sv
// Decode to execute, all registered in decode
interface decExIf;
   logic valid;
   pipePkg::aluOp_t aluOp;
   logic useImm;
   logic useShamt;
   logic regWrite;
   logic memRead;
   logic memWrite;
   logic isBranch;
   logic branchOnEqual;
   pipePkg::pcSel_t pcSel;
   isaPkg::regAddr_t dest;
   // Source numbers, needed for the execute forward match
   isaPkg::regAddr_t srcA;
   isaPkg::regAddr_t srcB;
   isaPkg::word_t opA;
   isaPkg::word_t opB;
   isaPkg::word_t imm;
   logic [4:0] shamt;
   isaPkg::target_t target;
   isaPkg::word_t pc;

   modport send(
      output valid, aluOp, useImm, useShamt, regWrite, memRead, memWrite,
      output isBranch, branchOnEqual, pcSel, dest, srcA, srcB,
      output opA, opB, imm, shamt, target, pc
   );
   modport receive(
      input valid, aluOp, useImm, useShamt, regWrite, memRead, memWrite,
      input isBranch, branchOnEqual, pcSel, dest, srcA, srcB,
      input opA, opB, imm, shamt, target, pc
   );
endinterface

// Execute to result
interface exResIf;
   isaPkg::word_t aluResult;
   isaPkg::regAddr_t dest;
   logic regWrite;
   logic memRead;
   logic link;
   isaPkg::word_t linkPc;
   // Unregistered, data memory latches them itself
   isaPkg::word_t memAddr;
   isaPkg::word_t storeData;
   logic storeEn;

   modport send(
      output aluResult, dest, regWrite, memRead, link, linkPc,
      output memAddr, storeData, storeEn
   );
   modport receive(
      input aluResult, dest, regWrite, memRead, link, linkPc,
      input memAddr, storeData, storeEn
   );
endinterface

// Taken branch or jump back to fetch
interface redirectIf;
   logic take;
   isaPkg::word_t target;

   modport send(output take, target);
   modport receive(input take, target);
endinterface

// Write-back bus, also the forwarding source
interface wbIf;
   logic we;
   isaPkg::regAddr_t addr;
   isaPkg::word_t data;

   modport send(output we, addr, data);
   modport receive(input we, addr, data);
endinterface

// File: hw/regFile.sv
module regFile (
   input logic clk,
   input isaPkg::regAddr_t readA,
   input isaPkg::regAddr_t readB,
   output isaPkg::word_t dataA,
   output isaPkg::word_t dataB,
   wbIf.receive wb
);

   isaPkg::word_t regs [32];

   // Register zero never takes a write
   always_ff @(posedge clk) begin
      if (wb.we && (wb.addr != '0)) begin
         regs[wb.addr] <= wb.data;
      end
   end

   // Combinational reads, r0 hardwired
   assign dataA = (readA == '0) ? '0 : regs[readA];
   assign dataB = (readB == '0) ? '0 : regs[readB];

endmodule

// File: hw/instrDecode.sv
module instrDecode #(
   parameter int imemAddrBits = 10
) (
   input logic clk,
   input logic reset,
   input logic imemWe,
   input isaPkg::word_t imemAddr,
   input isaPkg::word_t imemWrData,
   output isaPkg::regAddr_t readA,
   output isaPkg::regAddr_t readB,
   input isaPkg::word_t dataA,
   input isaPkg::word_t dataB,
   redirectIf.receive redirect,
   wbIf.receive wb,
   decExIf.send toExec
);

   isaPkg::word_t imem [2**imemAddrBits];
   isaPkg::word_t pcFetch;
   isaPkg::word_t fetchAddr;
   isaPkg::word_t pcDec;
   isaPkg::word_t instrWord;
   logic decValid;
   isaPkg::opcode_t opcode;
   isaPkg::funct_t funct;
   isaPkg::regAddr_t rs;
   isaPkg::regAddr_t rt;
   isaPkg::regAddr_t rd;
   isaPkg::imm_t immField;
   isaPkg::word_t immExt;
   isaPkg::word_t fwdA;
   isaPkg::word_t fwdB;
   pipePkg::aluOp_t aluOp;
   pipePkg::pcSel_t pcSel;
   isaPkg::regAddr_t dest;
   logic signExt;
   logic useImm;
   logic useShamt;
   logic regWrite;
   logic memRead;
   logic memWrite;
   logic isBranch;
   logic branchOnEqual;

   // Redirect wins, so the word read at this edge is the target
   assign fetchAddr = redirect.take ? redirect.target : pcFetch;

   always_ff @(posedge clk) begin
      if (reset) begin
         pcFetch <= '0;
         decValid <= 1'b0;
      end else begin
         pcFetch <= fetchAddr + isaPkg::word_t'(pipePkg::pcStep);
         // First word out of the memory after reset is stale
         decValid <= 1'b1;
      end
   end

   // Load port byte addressed, only open during reset
   always_ff @(posedge clk) begin
      if (reset && imemWe) begin
         imem[imemAddr[imemAddrBits+1:2]] <= imemWrData;
      end
      instrWord <= imem[fetchAddr[imemAddrBits+1:2]];
      pcDec <= fetchAddr;
   end

   // Field split
   assign opcode = isaPkg::opcode_t'(instrWord[isaPkg::opcodeLsb +: 6]);
   assign funct = isaPkg::funct_t'(instrWord[5:0]);
   assign rs = instrWord[isaPkg::rsLsb +: 5];
   assign rt = instrWord[isaPkg::rtLsb +: 5];
   assign rd = instrWord[isaPkg::rdLsb +: 5];
   assign immField = instrWord[15:0];
   assign immExt = signExt ? {{16{immField[15]}}, immField} : {16'h0000, immField};

   always_comb begin
      aluOp = pipePkg::aluAdd;
      pcSel = pipePkg::pcSeq;
      dest = rd;
      signExt = 1'b1;
      useImm = 1'b0;
      useShamt = 1'b0;
      regWrite = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      isBranch = 1'b0;
      branchOnEqual = 1'b0;
      case (opcode)
         isaPkg::opSpecial: begin
            regWrite = 1'b1;
            case (funct)
               isaPkg::fnAddu: aluOp = pipePkg::aluAdd;
               isaPkg::fnSubu: aluOp = pipePkg::aluSub;
               isaPkg::fnAnd: aluOp = pipePkg::aluAnd;
               isaPkg::fnOr: aluOp = pipePkg::aluOr;
               isaPkg::fnXor: aluOp = pipePkg::aluXor;
               isaPkg::fnSlt: aluOp = pipePkg::aluSlt;
               isaPkg::fnSll: begin
                  aluOp = pipePkg::aluSll;
                  useShamt = 1'b1;
               end
               isaPkg::fnSrl: begin
                  aluOp = pipePkg::aluSrl;
                  useShamt = 1'b1;
               end
               isaPkg::fnJr: begin
                  pcSel = pipePkg::pcReg;
                  regWrite = 1'b0;
               end
               // Unknown function code is a NOP
               default: regWrite = 1'b0;
            endcase
         end
         isaPkg::opAddiu: begin
            useImm = 1'b1;
            regWrite = 1'b1;
            dest = rt;
         end
         isaPkg::opOri: begin
            aluOp = pipePkg::aluOr;
            signExt = 1'b0;
            useImm = 1'b1;
            regWrite = 1'b1;
            dest = rt;
         end
         isaPkg::opLui: begin
            aluOp = pipePkg::aluLui;
            signExt = 1'b0;
            useImm = 1'b1;
            regWrite = 1'b1;
            dest = rt;
         end
         isaPkg::opLw: begin
            useImm = 1'b1;
            regWrite = 1'b1;
            memRead = 1'b1;
            dest = rt;
         end
         isaPkg::opSw: begin
            useImm = 1'b1;
            memWrite = 1'b1;
         end
         isaPkg::opBeq: begin
            isBranch = 1'b1;
            branchOnEqual = 1'b1;
            pcSel = pipePkg::pcBranch;
         end
         isaPkg::opBne: begin
            isBranch = 1'b1;
            pcSel = pipePkg::pcBranch;
         end
         isaPkg::opJ: pcSel = pipePkg::pcJump;
         isaPkg::opJal: begin
            pcSel = pipePkg::pcJump;
            regWrite = 1'b1;
            dest = isaPkg::linkReg;
         end
         default: regWrite = 1'b0;
      endcase
   end

   // Register read, bypass a write-back landing this same cycle
   assign readA = rs;
   assign readB = rt;
   assign fwdA = (wb.we && (wb.addr == rs)) ? wb.data : dataA;
   assign fwdB = (wb.we && (wb.addr == rt)) ? wb.data : dataB;

   always_ff @(posedge clk) begin
      if (reset) begin
         toExec.valid <= 1'b0;
         toExec.regWrite <= 1'b0;
         toExec.memRead <= 1'b0;
         toExec.memWrite <= 1'b0;
         toExec.isBranch <= 1'b0;
         toExec.pcSel <= pipePkg::pcSeq;
      end else begin
         toExec.valid <= decValid;
         // Writes to r0 dropped here, so they never reach write-back
         toExec.regWrite <= regWrite && (dest != '0);
         toExec.memRead <= memRead;
         toExec.memWrite <= memWrite;
         toExec.isBranch <= isBranch;
         toExec.pcSel <= pcSel;
      end
   end

   // Payload
   always_ff @(posedge clk) begin
      toExec.aluOp <= aluOp;
      toExec.useImm <= useImm;
      toExec.useShamt <= useShamt;
      toExec.branchOnEqual <= branchOnEqual;
      toExec.dest <= dest;
      toExec.srcA <= rs;
      toExec.srcB <= rt;
      toExec.opA <= fwdA;
      toExec.opB <= fwdB;
      toExec.imm <= immExt;
      toExec.shamt <= instrWord[isaPkg::shamtLsb +: 5];
      toExec.target <= instrWord[25:0];
      toExec.pc <= pcDec;
   end

endmodule

// File: hw/execute.sv
module execute (
   input logic clk,
   input logic reset,
   decExIf.receive fromDec,
   wbIf.receive wb,
   redirectIf.send redirect,
   exResIf.send toRes
);

   isaPkg::word_t opA;
   isaPkg::word_t opB;
   isaPkg::word_t aluA;
   isaPkg::word_t aluB;
   isaPkg::word_t aluOut;
   isaPkg::word_t pcPlus4;
   logic operandsEqual;
   logic branchTaken;

   // Forward from the instruction one ahead, now in result
   assign opA = (wb.we && (wb.addr == fromDec.srcA)) ? wb.data : fromDec.opA;
   assign opB = (wb.we && (wb.addr == fromDec.srcB)) ? wb.data : fromDec.opB;

   // Shifts take shamt on A, immediates replace B
   assign aluA = fromDec.useShamt ? {27'd0, fromDec.shamt} : opA;
   assign aluB = fromDec.useImm ? fromDec.imm : opB;

   always_comb begin
      case (fromDec.aluOp)
         pipePkg::aluAdd: aluOut = aluA + aluB;
         pipePkg::aluSub: aluOut = aluA - aluB;
         pipePkg::aluAnd: aluOut = aluA & aluB;
         pipePkg::aluOr: aluOut = aluA | aluB;
         pipePkg::aluXor: aluOut = aluA ^ aluB;
         pipePkg::aluSlt: aluOut = {31'd0, $signed(aluA) < $signed(aluB)};
         pipePkg::aluSll: aluOut = aluB << aluA[4:0];
         pipePkg::aluSrl: aluOut = aluB >> aluA[4:0];
         pipePkg::aluLui: aluOut = {aluB[15:0], 16'h0000};
         default: aluOut = aluA + aluB;
      endcase
   end

   // BEQ/BNE compare on the forwarded registers
   assign operandsEqual = (opA == opB);
   assign branchTaken = fromDec.isBranch ? (operandsEqual == fromDec.branchOnEqual)
                                         : (fromDec.pcSel != pipePkg::pcSeq);
   assign redirect.take = fromDec.valid && branchTaken;

   assign pcPlus4 = fromDec.pc + isaPkg::word_t'(pipePkg::pcStep);

   always_comb begin
      case (fromDec.pcSel)
         pipePkg::pcBranch: redirect.target = pcPlus4 + {fromDec.imm[29:0], 2'b00};
         pipePkg::pcJump: redirect.target = {pcPlus4[31:28], fromDec.target, 2'b00};
         pipePkg::pcReg: redirect.target = opA;
         default: redirect.target = pcPlus4;
      endcase
   end

   // Data memory access goes out this cycle
   assign toRes.memAddr = aluOut;
   assign toRes.storeData = opB;
   assign toRes.storeEn = fromDec.valid && fromDec.memWrite;

   always_ff @(posedge clk) begin
      if (reset) begin
         toRes.regWrite <= 1'b0;
         toRes.memRead <= 1'b0;
         toRes.link <= 1'b0;
      end else begin
         toRes.regWrite <= fromDec.valid && fromDec.regWrite;
         toRes.memRead <= fromDec.valid && fromDec.memRead;
         // Only JAL both jumps and writes
         toRes.link <= fromDec.valid && fromDec.regWrite
                       && (fromDec.pcSel == pipePkg::pcJump);
      end
   end

   always_ff @(posedge clk) begin
      toRes.aluResult <= aluOut;
      toRes.dest <= fromDec.dest;
      toRes.linkPc <= fromDec.pc;
   end

endmodule

// File: hw/result.sv
module result #(
   parameter int dmemAddrBits = 10
) (
   input logic clk,
   input logic reset,
   exResIf.receive fromExec,
   wbIf.send wb
);

   isaPkg::word_t dmem [2**dmemAddrBits];
   isaPkg::word_t loadWord;
   isaPkg::word_t linkValue;
   logic [dmemAddrBits-1:0] wordIndex;

   // Low two address bits ignored
   assign wordIndex = fromExec.memAddr[dmemAddrBits+1:2];

   // Latches on the same edge as the execute register
   always_ff @(posedge clk) begin
      // No stores land while held in reset
      if (fromExec.storeEn && !reset) begin
         dmem[wordIndex] <= fromExec.storeData;
      end
      loadWord <= dmem[wordIndex];
   end

   assign linkValue = fromExec.linkPc + isaPkg::word_t'(pipePkg::linkOffset);

   assign wb.we = fromExec.regWrite;
   // JAL already carries linkReg as its destination
   assign wb.addr = fromExec.dest;

   always_comb begin
      if (fromExec.link) begin
         wb.data = linkValue;
      end else if (fromExec.memRead) begin
         wb.data = loadWord;
      end else begin
         wb.data = fromExec.aluResult;
      end
   end

endmodule

// File: hw/mipsCore.sv
module mipsCore #(
   parameter int imemAddrBits = 10,
   parameter int dmemAddrBits = 10
) (
   input logic clk,
   input logic reset,
   input logic imemWe,
   input isaPkg::word_t imemAddr,
   input isaPkg::word_t imemWrData,
   output logic wbValid,
   output isaPkg::regAddr_t wbAddr,
   output isaPkg::word_t wbData
);

   isaPkg::regAddr_t readA;
   isaPkg::regAddr_t readB;
   isaPkg::word_t dataA;
   isaPkg::word_t dataB;

   decExIf decEx();
   exResIf exRes();
   redirectIf redir();
   wbIf wbBus();

   instrDecode #(
      .imemAddrBits(imemAddrBits)
   ) decodeStage (
      .clk(clk),
      .reset(reset),
      .imemWe(imemWe),
      .imemAddr(imemAddr),
      .imemWrData(imemWrData),
      .readA(readA),
      .readB(readB),
      .dataA(dataA),
      .dataB(dataB),
      .redirect(redir.receive),
      .wb(wbBus.receive),
      .toExec(decEx.send)
   );

   regFile registers (
      .clk(clk),
      .readA(readA),
      .readB(readB),
      .dataA(dataA),
      .dataB(dataB),
      .wb(wbBus.receive)
   );

   execute executeStage (
      .clk(clk),
      .reset(reset),
      .fromDec(decEx.receive),
      .wb(wbBus.receive),
      .redirect(redir.send),
      .toRes(exRes.send)
   );

   result #(
      .dmemAddrBits(dmemAddrBits)
   ) resultStage (
      .clk(clk),
      .reset(reset),
      .fromExec(exRes.receive),
      .wb(wbBus.send)
   );

   // Write-back mirrored out for the testbench
   assign wbValid = wbBus.we;
   assign wbAddr = wbBus.addr;
   assign wbData = wbBus.data;

endmodule

// File: testbench/tbClock.sv
module tbClock #(
   parameter int periodNs = 20
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 1ps;

   // Starts low, toggles every half period
   initial begin
      clk = 1'b0;
      forever #(periodNs / 2) clk = ~clk;
   end

endmodule

// File: testbench/mipsCore_assert.sv
module mipsCoreAssert (
   input logic clk,
   input logic reset,
   input logic wbValid,
   input isaPkg::regAddr_t wbAddr,
   input isaPkg::word_t wbData
);
   timeunit 1ns;
   timeprecision 1ps;

   // Sync reset, so the pipe is clear from the second reset edge on
   quietInReset: assert property (@(posedge clk) (reset && $past(reset)) |-> !wbValid)
      else $error("write-back strobe high while reset is held");

   // r0 writes are dropped in decode
   noZeroDest: assert property (@(posedge clk) disable iff (reset) wbValid |-> (wbAddr != '0))
      else $error("write-back addressed to register zero");

   knownStrobe: assert property (@(posedge clk) disable iff (reset) !$isunknown(wbValid))
      else $error("write-back strobe unknown");

   // Address and data fully driven on every retire
   knownPayload: assert property (@(posedge clk) disable iff (reset)
      wbValid |-> !$isunknown({wbAddr, wbData}))
      else $error("write-back address or data unknown");

endmodule

bind mipsCore mipsCoreAssert coreChecks (
   .clk(clk),
   .reset(reset),
   .wbValid(wbValid),
   .wbAddr(wbAddr),
   .wbData(wbData)
);

// File: testbench/mipsCoreTb.sv
module mipsCoreTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int resetCycles = 5;
   localparam int retireTimeout = 2000;
   localparam int drainCycles = 20;
   localparam int maxFileTokens = 1000;
   localparam string goldenPath = "testbench/programGolden.txt";

   logic clk;
   logic reset;
   logic imemWe;
   isaPkg::word_t imemAddr;
   isaPkg::word_t imemWrData;
   logic wbValid;
   isaPkg::regAddr_t wbAddr;
   isaPkg::word_t wbData;

   // Program image and expected retire order
   isaPkg::word_t progAddr [$];
   isaPkg::word_t progWord [$];
   isaPkg::regAddr_t expReg [$];
   isaPkg::word_t expData [$];

   int nextExp = 0;
   int valueErrors = 0;
   int otherErrors = 0;

   tbClock #(
      .periodNs(20)
   ) clockGen (
      .clk(clk)
   );

   mipsCore #(
      .imemAddrBits(10),
      .dmemAddrBits(10)
   ) uut (
      .clk(clk),
      .reset(reset),
      .imemWe(imemWe),
      .imemAddr(imemAddr),
      .imemWrData(imemWrData),
      .wbValid(wbValid),
      .wbAddr(wbAddr),
      .wbData(wbData)
   );

   // P records go to the program, W records to the expected queue
   task automatic readGolden();
      int fd;
      int code;
      int tokens;
      logic [7:0] tag;
      isaPkg::word_t first;
      isaPkg::word_t second;
      logic [8*128-1:0] skipped;
      tokens = 0;
      fd = $fopen(goldenPath, "r");
      if (fd == 0) begin
         $display("Could not open the golden file %s", goldenPath);
         otherErrors++;
         return;
      end
      while (tokens < maxFileTokens) begin
         tokens++;
         code = $fscanf(fd, "%s", tag);
         if (code != 1) begin
            break;
         end
         if (tag == "#") begin
            code = $fgets(skipped, fd);
         end else if (tag == "P" || tag == "W") begin
            code = $fscanf(fd, "%h %h", first, second);
            if (code != 2) begin
               $display("Malformed record in the golden file");
               otherErrors++;
            end else if (tag == "P") begin
               progAddr.push_back(first);
               progWord.push_back(second);
            end else begin
               expReg.push_back(first[4:0]);
               expData.push_back(second);
            end
         end else begin
            $display("Unknown record type in the golden file");
            otherErrors++;
            code = $fgets(skipped, fd);
         end
      end
      $fclose(fd);
   endtask

   // One word per cycle through the load port, reset held throughout
   task automatic loadProgram();
      int i;
      for (i = 0; i < progAddr.size(); i++) begin
         @(posedge clk);
         imemWe <= 1'b1;
         imemAddr <= progAddr[i];
         imemWrData <= progWord[i];
      end
      @(posedge clk);
      imemWe <= 1'b0;
   endtask

   // Compare one retire event against the next expected entry
   task automatic checkWriteBack();
      if (nextExp >= expReg.size()) begin
         $display("Unexpected write-back to register %0d after the last expected one", wbAddr);
         otherErrors++;
      end else begin
         if (wbAddr !== expReg[nextExp]) begin
            $display("[FAIL] wbAddr: expected 0x%h, got 0x%h (write-back %0d)",
                     expReg[nextExp], wbAddr, nextExp);
            valueErrors++;
         end
         if (wbData !== expData[nextExp]) begin
            $display("[FAIL] wbData: expected 0x%h, got 0x%h (write-back %0d)",
                     expData[nextExp], wbData, nextExp);
            valueErrors++;
         end
         nextExp++;
      end
   endtask

   task automatic waitForRetire();
      int cycles;
      cycles = 0;
      while (nextExp < expReg.size() && cycles < retireTimeout) begin
         @(posedge clk);
         cycles++;
      end
      if (nextExp < expReg.size()) begin
         $display("Timed out after %0d cycles with %0d of %0d write-backs seen",
                  cycles, nextExp, expReg.size());
         otherErrors++;
      end
   endtask

   // Outputs settle after the rising edge, so sample on the falling one
   always @(negedge clk) begin
      if (reset) begin
         if (wbValid) begin
            $display("Write-back seen while reset is high");
            otherErrors++;
         end
      end else if (wbValid) begin
         checkWriteBack();
      end
   end

   initial begin
      int cycles;
      reset = 1'b1;
      imemWe = 1'b0;
      imemAddr = '0;
      imemWrData = '0;
      readGolden();
      if (expReg.size() == 0) begin
         $display("The golden file holds no expected write-backs");
         otherErrors++;
      end
      loadProgram();
      // Extra reset cycles past the last load
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;
      waitForRetire();
      // Short window to catch stray write-backs once the program idles
      cycles = 0;
      while (cycles < drainCycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("Done: %0d value mismatches, %0d other errors", valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: testbench/programGolden.txt
# P <byte address> <instruction word>, both hex
# W <register> <value>, both hex, in write-back order
# ALU ops, immediates, shifts, forwarding one and two back
P 00000000 24010005
P 00000004 2402fffd
P 00000008 00221821
P 0000000c 00612023
P 00000010 3405f0f0
P 00000014 3c061234
P 00000018 00c53825
P 0000001c 00e54024
P 00000020 00e54826
P 00000024 0041502a
P 00000028 0022582a
P 0000002c 00016100
P 00000030 00076a02
# Stores, loads, load value two back
P 00000034 ac0c0014
P 00000038 ac070010
P 0000003c 8c0e0010
P 00000040 8c0f0014
P 00000044 24100001
P 00000048 01cf8821
# beq taken, bne not taken, j, jal and jr with delay slots
P 0000004c 10210002
P 00000050 24120007
P 00000054 24130099
P 00000058 14210002
P 0000005c 24130011
P 00000060 24140022
P 00000064 0800001c
P 00000068 24150033
P 0000006c 24160044
P 00000070 0c000021
P 00000074 24170055
P 00000078 24180066
P 0000007c 0800001f
P 00000080 00000000
P 00000084 27f90004
P 00000088 03e00008
P 0000008c 241a0077
# Expected write-backs
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 fffffffd
W 05 0000f0f0
W 06 12340000
W 07 1234f0f0
W 08 0000f0f0
W 09 12340000
W 0a 00000001
W 0b 00000000
W 0c 00000050
W 0d 001234f0
W 0e 1234f0f0
W 0f 00000050
W 10 00000001
W 11 1234f140
W 12 00000007
W 13 00000011
W 14 00000022
W 15 00000033
W 1f 00000078
W 17 00000055
W 19 0000007c
W 1a 00000077
W 18 00000066

// File: sources.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/stageIf.sv
hw/regFile.sv
hw/instrDecode.sv
hw/execute.sv
hw/result.sv
hw/mipsCore.sv
testbench/tbClock.sv
testbench/mipsCore_assert.sv
testbench/mipsCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= mipsCoreTb
FLAGS ?= --binary --timing --assert
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f

.PHONY: build run clean

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
